// File: src/core_pkg.sv
// widths, CSR addresses, memory size codes, stage payload structs
package core_pkg;

  localparam int XLEN        = 64;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  // doublewords, indexed by address bits 10..3
  localparam int DMEM_DEPTH  = 256;

  // implemented machine CSRs
  localparam logic [CSR_ADDR_WD-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_WD-1:0] CSR_MCAUSE  = 12'h342;

  typedef enum logic [1:0] {
    MEM_BYTE   = 2'd0,
    MEM_HALF   = 2'd1,
    MEM_WORD   = 2'd2,
    MEM_DOUBLE = 2'd3
  } mem_size_t;

  // execute -> memory
  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [31:0]            inst;
    logic [XLEN-1:0]        alu_result;
    logic [GPR_ADDR_WD-1:0] rd;
    logic                   gpr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    mem_size_t              mem_size;
    logic                   mem_unsigned;
    logic [XLEN-1:0]        store_data;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr_addr;
    logic [XLEN-1:0]        csr_wdata;
  } ms_payload_t;

  // memory -> write-back, result and trace info in one record
  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [31:0]            inst;
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        gpr_result;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr_addr;
    logic [XLEN-1:0]        csr_result;
    logic                   mem_en;
    logic [XLEN-1:0]        mem_addr;
  } ws_payload_t;

endpackage

// File: src/rf_write_if.sv
// GPR and CSR write port bundle with writer and register file modports
`timescale 1ns/1ps

interface rf_write_if;
  import core_pkg::*;

  logic                   gpr_wen;
  logic [GPR_ADDR_WD-1:0] gpr_waddr;
  logic [XLEN-1:0]        gpr_wdata;
  logic                   csr_wen;
  logic [CSR_ADDR_WD-1:0] csr_waddr;
  logic [XLEN-1:0]        csr_wdata;

  modport writer (
    output gpr_wen, gpr_waddr, gpr_wdata,
    output csr_wen, csr_waddr, csr_wdata
  );

  modport gpr (input gpr_wen, gpr_waddr, gpr_wdata);

  modport csr (input csr_wen, csr_waddr, csr_wdata);

endinterface

// File: src/stage_slot.sv
// pipeline slot: valid bit, typed payload register, allowin/ready_go handshake
`timescale 1ns/1ps

module stage_slot #(
  parameter type T_PAYLOAD = logic
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_valid,
  input  T_PAYLOAD i_payload,
  input  logic     i_ready_go,
  input  logic     i_next_allowin,
  output logic     o_allowin,
  output logic     o_valid,
  output T_PAYLOAD o_payload
);

  logic valid_q;

  assign o_allowin = !valid_q || (i_ready_go && i_next_allowin);
  assign o_valid   = valid_q && i_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_allowin) begin
      valid_q <= i_valid;
    end
  end

  // payload only captured on a real transfer
  always_ff @(posedge i_clk) begin
    if (i_valid && o_allowin) begin
      o_payload <= i_payload;
    end
  end

endmodule

// File: src/data_mem.sv
// byte-masked doubleword data memory, synchronous write and read
`timescale 1ns/1ps

module data_mem (
  input  logic                      i_clk,
  input  logic                      i_ren,
  input  logic                      i_wen,
  input  logic [core_pkg::XLEN-1:0] i_addr,
  input  logic [core_pkg::XLEN-1:0] i_wdata,
  input  logic [7:0]                i_wstrb,
  output logic [core_pkg::XLEN-1:0] o_rdata
);
  import core_pkg::*;

  logic [XLEN-1:0]               mem [DMEM_DEPTH];
  logic [$clog2(DMEM_DEPTH)-1:0] idx;

  // upper address bits wrap
  assign idx = i_addr[3 +: $clog2(DMEM_DEPTH)];

  initial begin
    for (int i = 0; i < DMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wstrb[b]) begin
          mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= mem[idx];
    end
  end

endmodule

// File: src/mem_stage.sv
// memory stage: store issue, load issue and wait, load data extraction
`timescale 1ns/1ps

module mem_stage (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_es_valid,
  input  core_pkg::ms_payload_t i_es_payload,
  output logic                  o_es_allowin,
  output logic                  o_ms_valid,
  output core_pkg::ws_payload_t o_ms_payload,
  input  logic                  i_ws_allowin
);
  import core_pkg::*;

  ms_payload_t     ms_p;
  logic            wait_q;
  logic            ms_ready_go;
  logic [XLEN-1:0] dmem_rdata;
  logic [XLEN-1:0] st_data;
  logic [7:0]      st_base;
  logic [7:0]      st_strb;
  logic [XLEN-1:0] ld_shifted;
  logic [XLEN-1:0] ld_value;
  logic [2:0]      byte_off;

  assign ms_ready_go = !wait_q;

  stage_slot #(
    .T_PAYLOAD (ms_payload_t)
  ) u_ms_slot (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_es_valid),
    .i_payload      (i_es_payload),
    .i_ready_go     (ms_ready_go),
    .i_next_allowin (i_ws_allowin),
    .o_allowin      (o_es_allowin),
    .o_valid        (o_ms_valid),
    .o_payload      (ms_p)
  );

  // high for exactly the first cycle of a load
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= i_es_valid && o_es_allowin && i_es_payload.mem_ren;
    end
  end

  assign byte_off = ms_p.alu_result[2:0];

  always_comb begin
    case (ms_p.mem_size)
      MEM_BYTE: st_base = 8'h01;
      MEM_HALF: st_base = 8'h03;
      MEM_WORD: st_base = 8'h0f;
      default:  st_base = 8'hff;
    endcase
  end

  assign st_strb = st_base << byte_off;
  assign st_data = ms_p.store_data << {byte_off, 3'b000};

  data_mem u_dmem (
    .i_clk   (i_clk),
    .i_ren   (wait_q),
    .i_wen   (o_ms_valid && ms_p.mem_wen),
    .i_addr  (ms_p.alu_result),
    .i_wdata (st_data),
    .i_wstrb (st_strb),
    .o_rdata (dmem_rdata)
  );

  assign ld_shifted = dmem_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (ms_p.mem_size)
      MEM_BYTE: ld_value = ms_p.mem_unsigned ? {{(XLEN-8){1'b0}}, ld_shifted[7:0]} :
                                               {{(XLEN-8){ld_shifted[7]}}, ld_shifted[7:0]};
      MEM_HALF: ld_value = ms_p.mem_unsigned ? {{(XLEN-16){1'b0}}, ld_shifted[15:0]} :
                                               {{(XLEN-16){ld_shifted[15]}}, ld_shifted[15:0]};
      MEM_WORD: ld_value = ms_p.mem_unsigned ? {{(XLEN-32){1'b0}}, ld_shifted[31:0]} :
                                               {{(XLEN-32){ld_shifted[31]}}, ld_shifted[31:0]};
      default:  ld_value = ld_shifted;
    endcase
  end

  always_comb begin
    o_ms_payload.pc         = ms_p.pc;
    o_ms_payload.inst       = ms_p.inst;
    o_ms_payload.gpr_wen    = ms_p.gpr_wen;
    o_ms_payload.rd         = ms_p.rd;
    o_ms_payload.gpr_result = ms_p.mem_ren ? ld_value : ms_p.alu_result;
    o_ms_payload.csr_wen    = ms_p.csr_wen;
    o_ms_payload.csr_addr   = ms_p.csr_addr;
    o_ms_payload.csr_result = ms_p.csr_wdata;
    // trace info for the commit record
    o_ms_payload.mem_en     = ms_p.mem_ren || ms_p.mem_wen;
    o_ms_payload.mem_addr   = ms_p.alu_result;
  end

endmodule

// File: src/wb_stage.sv
// write-back stage: register file writes, decode bypass, commit record
`timescale 1ns/1ps

module wb_stage (
  input  logic                               i_clk,
  input  logic                               i_rst,
  input  logic                               i_ms_valid,
  input  core_pkg::ws_payload_t              i_ms_payload,
  output logic                               o_ws_allowin,
  rf_write_if.writer                         rf,
  output logic                               o_bypass_gpr_valid,
  output logic [core_pkg::GPR_ADDR_WD-1:0]   o_bypass_gpr_addr,
  output logic [core_pkg::XLEN-1:0]          o_bypass_gpr_data,
  output logic                               o_bypass_csr_valid,
  output logic [core_pkg::CSR_ADDR_WD-1:0]   o_bypass_csr_addr,
  output logic [core_pkg::XLEN-1:0]          o_bypass_csr_data,
  output logic                               o_commit_valid,
  output logic [core_pkg::XLEN-1:0]          o_commit_pc,
  output logic [31:0]                        o_commit_inst,
  output logic                               o_commit_mem_en,
  output logic [core_pkg::XLEN-1:0]          o_commit_mem_addr
);
  import core_pkg::*;

  ws_payload_t ws_p;
  logic        ws_valid;

  // last stage, never holds back
  stage_slot #(
    .T_PAYLOAD (ws_payload_t)
  ) u_ws_slot (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_ms_valid),
    .i_payload      (i_ms_payload),
    .i_ready_go     (1'b1),
    .i_next_allowin (1'b1),
    .o_allowin      (o_ws_allowin),
    .o_valid        (ws_valid),
    .o_payload      (ws_p)
  );

  assign rf.gpr_wen   = ws_valid && ws_p.gpr_wen;
  assign rf.gpr_waddr = ws_p.rd;
  assign rf.gpr_wdata = ws_p.gpr_result;
  assign rf.csr_wen   = ws_valid && ws_p.csr_wen;
  assign rf.csr_waddr = ws_p.csr_addr;
  assign rf.csr_wdata = ws_p.csr_result;

  // bypass zeroed unless a write is really pending
  assign o_bypass_gpr_valid = rf.gpr_wen;
  assign o_bypass_gpr_addr  = {GPR_ADDR_WD{rf.gpr_wen}} & ws_p.rd;
  assign o_bypass_gpr_data  = {XLEN{rf.gpr_wen}} & ws_p.gpr_result;
  assign o_bypass_csr_valid = rf.csr_wen;
  assign o_bypass_csr_addr  = {CSR_ADDR_WD{rf.csr_wen}} & ws_p.csr_addr;
  assign o_bypass_csr_data  = {XLEN{rf.csr_wen}} & ws_p.csr_result;

  assign o_commit_valid    = ws_valid;
  assign o_commit_pc       = ws_p.pc;
  assign o_commit_inst     = ws_p.inst;
  assign o_commit_mem_en   = ws_p.mem_en;
  assign o_commit_mem_addr = ws_p.mem_addr;

endmodule

// File: src/gpr_file.sv
// general register file, 32 x 64 bits, x0 hardwired to zero
`timescale 1ns/1ps

module gpr_file (
  input  logic                             i_clk,
  input  logic                             i_rst,
  rf_write_if.gpr                          wr,
  input  logic [core_pkg::GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [core_pkg::GPR_ADDR_WD-1:0] i_raddr2,
  output logic [core_pkg::XLEN-1:0]        o_rdata1,
  output logic [core_pkg::XLEN-1:0]        o_rdata2
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [2**GPR_ADDR_WD];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 2**GPR_ADDR_WD; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.gpr_wen && (wr.gpr_waddr != '0)) begin
      // x0 writes dropped
      regs[wr.gpr_waddr] <= wr.gpr_wdata;
    end
  end

  // no write-to-read forwarding
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

endmodule

// File: src/csr_file.sv
// machine CSR store: mstatus, mtvec, mepc, mcause
`timescale 1ns/1ps

module csr_file (
  input  logic                             i_clk,
  input  logic                             i_rst,
  rf_write_if.csr                          wr,
  input  logic [core_pkg::CSR_ADDR_WD-1:0] i_raddr,
  output logic [core_pkg::XLEN-1:0]        o_rdata
);
  import core_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (wr.csr_wen) begin
      case (wr.csr_waddr)
        CSR_MSTATUS: mstatus <= wr.csr_wdata;
        CSR_MTVEC:   mtvec   <= wr.csr_wdata;
        CSR_MEPC:    mepc    <= wr.csr_wdata;
        CSR_MCAUSE:  mcause  <= wr.csr_wdata;
        default:     ;
      endcase
    end
  end

  // unimplemented addresses read as zero
  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_MEPC:    o_rdata = mepc;
      CSR_MCAUSE:  o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

endmodule

// File: src/wb_core_top.sv
// pipeline back end top: memory stage, write-back stage, GPR and CSR files
`timescale 1ns/1ps

module wb_core_top (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_es_valid,
  output logic                             o_es_allowin,
  input  logic [core_pkg::XLEN-1:0]        i_es_pc,
  input  logic [31:0]                      i_es_inst,
  input  logic [core_pkg::XLEN-1:0]        i_es_alu_result,
  input  logic [core_pkg::GPR_ADDR_WD-1:0] i_es_rd,
  input  logic                             i_es_gpr_wen,
  input  logic                             i_es_mem_ren,
  input  logic                             i_es_mem_wen,
  input  core_pkg::mem_size_t              i_es_mem_size,
  input  logic                             i_es_mem_unsigned,
  input  logic [core_pkg::XLEN-1:0]        i_es_store_data,
  input  logic                             i_es_csr_wen,
  input  logic [core_pkg::CSR_ADDR_WD-1:0] i_es_csr_addr,
  input  logic [core_pkg::XLEN-1:0]        i_es_csr_wdata,
  input  logic [core_pkg::GPR_ADDR_WD-1:0] i_gpr_raddr1,
  input  logic [core_pkg::GPR_ADDR_WD-1:0] i_gpr_raddr2,
  output logic [core_pkg::XLEN-1:0]        o_gpr_rdata1,
  output logic [core_pkg::XLEN-1:0]        o_gpr_rdata2,
  input  logic [core_pkg::CSR_ADDR_WD-1:0] i_csr_raddr,
  output logic [core_pkg::XLEN-1:0]        o_csr_rdata,
  output logic                             o_bypass_gpr_valid,
  output logic [core_pkg::GPR_ADDR_WD-1:0] o_bypass_gpr_addr,
  output logic [core_pkg::XLEN-1:0]        o_bypass_gpr_data,
  output logic                             o_bypass_csr_valid,
  output logic [core_pkg::CSR_ADDR_WD-1:0] o_bypass_csr_addr,
  output logic [core_pkg::XLEN-1:0]        o_bypass_csr_data,
  output logic                             o_commit_valid,
  output logic [core_pkg::XLEN-1:0]        o_commit_pc,
  output logic [31:0]                      o_commit_inst,
  output logic                             o_commit_mem_en,
  output logic [core_pkg::XLEN-1:0]        o_commit_mem_addr
);
  import core_pkg::*;

  ms_payload_t es_payload;
  ws_payload_t ms_to_ws_payload;
  logic        ms_to_ws_valid;
  logic        ws_allowin;

  rf_write_if u_rf_wr ();

  // execute fields into one record
  assign es_payload.pc           = i_es_pc;
  assign es_payload.inst         = i_es_inst;
  assign es_payload.alu_result   = i_es_alu_result;
  assign es_payload.rd           = i_es_rd;
  assign es_payload.gpr_wen      = i_es_gpr_wen;
  assign es_payload.mem_ren      = i_es_mem_ren;
  assign es_payload.mem_wen      = i_es_mem_wen;
  assign es_payload.mem_size     = i_es_mem_size;
  assign es_payload.mem_unsigned = i_es_mem_unsigned;
  assign es_payload.store_data   = i_es_store_data;
  assign es_payload.csr_wen      = i_es_csr_wen;
  assign es_payload.csr_addr     = i_es_csr_addr;
  assign es_payload.csr_wdata    = i_es_csr_wdata;

  mem_stage u_mem_stage (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_es_valid   (i_es_valid),
    .i_es_payload (es_payload),
    .o_es_allowin (o_es_allowin),
    .o_ms_valid   (ms_to_ws_valid),
    .o_ms_payload (ms_to_ws_payload),
    .i_ws_allowin (ws_allowin)
  );

  wb_stage u_wb_stage (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_ms_valid         (ms_to_ws_valid),
    .i_ms_payload       (ms_to_ws_payload),
    .o_ws_allowin       (ws_allowin),
    .rf                 (u_rf_wr.writer),
    .o_bypass_gpr_valid (o_bypass_gpr_valid),
    .o_bypass_gpr_addr  (o_bypass_gpr_addr),
    .o_bypass_gpr_data  (o_bypass_gpr_data),
    .o_bypass_csr_valid (o_bypass_csr_valid),
    .o_bypass_csr_addr  (o_bypass_csr_addr),
    .o_bypass_csr_data  (o_bypass_csr_data),
    .o_commit_valid     (o_commit_valid),
    .o_commit_pc        (o_commit_pc),
    .o_commit_inst      (o_commit_inst),
    .o_commit_mem_en    (o_commit_mem_en),
    .o_commit_mem_addr  (o_commit_mem_addr)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .wr       (u_rf_wr.gpr),
    .i_raddr1 (i_gpr_raddr1),
    .i_raddr2 (i_gpr_raddr2),
    .o_rdata1 (o_gpr_rdata1),
    .o_rdata2 (o_gpr_rdata2)
  );

  csr_file u_csr_file (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .wr      (u_rf_wr.csr),
    .i_raddr (i_csr_raddr),
    .o_rdata (o_csr_rdata)
  );

endmodule

// File: verification/tb_wb_core.sv
// wb_core_top testbench with random instruction stream, reference model, commit and register checks
`timescale 1ns/1ps

module tb_wb_core;
  import core_pkg::*;

  localparam int N_INSTR   = 400;
  localparam int CYC_LIMIT = 4 * N_INSTR + 100;

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] inst;
    logic        gpr_wen;
    logic [4:0]  rd;
    logic [63:0] result;
    logic        csr_wen;
    logic [11:0] csr_addr;
    logic [63:0] csr_data;
    logic        mem_en;
    logic [63:0] mem_addr;
    logic [31:0] commit_cyc;
  } expect_t;

  logic i_clk, i_rst, i_es_valid, o_es_allowin;
  logic [XLEN-1:0] i_es_pc, i_es_alu_result, i_es_store_data, i_es_csr_wdata;
  logic [31:0] i_es_inst;
  logic [GPR_ADDR_WD-1:0] i_es_rd, i_gpr_raddr1, i_gpr_raddr2, o_bypass_gpr_addr;
  logic i_es_gpr_wen, i_es_mem_ren, i_es_mem_wen, i_es_mem_unsigned, i_es_csr_wen;
  mem_size_t i_es_mem_size;
  logic [CSR_ADDR_WD-1:0] i_es_csr_addr, i_csr_raddr, o_bypass_csr_addr;
  logic [XLEN-1:0] o_gpr_rdata1, o_gpr_rdata2, o_csr_rdata, o_bypass_gpr_data;
  logic [XLEN-1:0] o_bypass_csr_data, o_commit_pc, o_commit_mem_addr;
  logic o_bypass_gpr_valid, o_bypass_csr_valid, o_commit_valid, o_commit_mem_en;
  logic [31:0] o_commit_inst;

  logic [63:0] model_mem [DMEM_DEPTH];
  logic [63:0] model_gpr [32];
  logic [63:0] model_csr [4];
  expect_t     exp_q [$];
  logic [11:0] csr_probe [8] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE,
                                 12'h000, 12'h301, 12'h7c0, 12'hfff};
  int unsigned seed_dummy;
  int   cycles, cyc, n_acc, n_value_err, n_other_err;
  logic hold, load_in_ms, pend_valid;
  logic [4:0]  pend_rd;
  logic [11:0] pend_csr;
  logic [63:0] next_pc;

  wb_core_top i_wb_core_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic int csr_index(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return 0;
      CSR_MTVEC:   return 1;
      CSR_MEPC:    return 2;
      CSR_MCAUSE:  return 3;
      default:     return -1;
    endcase
  endfunction

  function automatic logic [63:0] csr_expect(input logic [11:0] addr);
    int k;
    k = csr_index(addr);
    return (k < 0) ? 64'd0 : model_csr[k];
  endfunction

  // byte-wise read of the model memory and extension to 64 bits
  function automatic logic [63:0] load_model(input logic [63:0] addr, input logic [1:0] size,
                                             input logic uns);
    logic [63:0] val;
    int nb;
    nb = 1 << size;
    val = '0;
    for (int b = 0; b < nb; b++) begin
      val[b*8 +: 8] = model_mem[addr[10:3]][(addr[2:0] + b)*8 +: 8];
    end
    if (!uns && nb < 8 && val[nb*8-1]) begin
      val = val | ~((64'd1 << (nb*8)) - 64'd1);
    end
    return val;
  endfunction

  task automatic store_model(input logic [63:0] addr, input logic [1:0] size,
                             input logic [63:0] data);
    for (int b = 0; b < (1 << size); b++) begin
      model_mem[addr[10:3]][(addr[2:0] + b)*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      n_value_err++;
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d value mismatches, %0d other failures", n_value_err, n_other_err);
  endtask

  task automatic offer_instr();
    int kind;
    logic [2:0] off;
    kind = $urandom_range(0, 9);
    i_es_valid        = 1'b1;
    i_es_pc           = next_pc;
    next_pc           = next_pc + 4;
    i_es_inst         = $urandom;
    i_es_rd           = 5'($urandom_range(0, 31));
    i_es_mem_size     = mem_size_t'($urandom_range(0, 3));
    i_es_mem_unsigned = $urandom_range(0, 1);
    i_es_store_data   = {$urandom, $urandom};
    i_es_csr_wdata    = {$urandom, $urandom};
    i_es_alu_result   = {$urandom, $urandom};
    i_es_mem_ren      = (kind == 4 || kind == 5);
    i_es_mem_wen      = (kind == 6 || kind == 7);
    i_es_csr_wen      = (kind >= 8);
    i_es_gpr_wen      = i_es_mem_ren || (!i_es_mem_wen && $urandom_range(0, 7) != 0);
    case ($urandom_range(0, 5))
      0:       i_es_csr_addr = CSR_MSTATUS;
      1:       i_es_csr_addr = CSR_MTVEC;
      2:       i_es_csr_addr = CSR_MEPC;
      3:       i_es_csr_addr = CSR_MCAUSE;
      default: i_es_csr_addr = 12'($urandom);
    endcase
    if (i_es_mem_ren || i_es_mem_wen) begin
      // aligned access in the low 32 doublewords, so loads often hit earlier stores
      off = $urandom_range(0, 7);
      off = off & ~((3'd1 << i_es_mem_size) - 3'd1);
      i_es_alu_result = {53'd0, 8'($urandom_range(0, 31)), off};
    end
  endtask

  task automatic accept_instr();
    expect_t e;
    e.pc       = i_es_pc;
    e.inst     = i_es_inst;
    e.gpr_wen  = i_es_gpr_wen;
    e.rd       = i_es_rd;
    e.result   = i_es_mem_ren ?
                 load_model(i_es_alu_result, i_es_mem_size, i_es_mem_unsigned) : i_es_alu_result;
    e.csr_wen  = i_es_csr_wen;
    e.csr_addr = i_es_csr_addr;
    e.csr_data = i_es_csr_wdata;
    e.mem_en   = i_es_mem_ren || i_es_mem_wen;
    e.mem_addr = i_es_alu_result;
    // two cycles to commit plus a load's wait cycle
    e.commit_cyc = cyc + 2 + i_es_mem_ren;
    if (i_es_mem_wen) begin
      store_model(i_es_alu_result, i_es_mem_size, i_es_store_data);
    end
    exp_q.push_back(e);
    n_acc++;
  endtask

  task automatic check_cycle();
    expect_t e;
    logic accepted;
    if (pend_valid) begin
      compare_value("o_gpr_rdata1", model_gpr[pend_rd], o_gpr_rdata1);
      compare_value("o_csr_rdata", csr_expect(pend_csr), o_csr_rdata);
    end
    compare_value("o_es_allowin", !load_in_ms, o_es_allowin);
    if (!o_bypass_gpr_valid) begin
      compare_value("o_bypass_gpr_addr", 0, o_bypass_gpr_addr);
      compare_value("o_bypass_gpr_data", 0, o_bypass_gpr_data);
    end
    if (!o_bypass_csr_valid) begin
      compare_value("o_bypass_csr_addr", 0, o_bypass_csr_addr);
      compare_value("o_bypass_csr_data", 0, o_bypass_csr_data);
    end
    pend_valid = o_commit_valid;
    if (o_commit_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("commit at %0t with no accepted instruction left to retire", $time);
        n_other_err++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        compare_value("commit cycle", e.commit_cyc, cyc);
        compare_value("o_commit_pc", e.pc, o_commit_pc);
        compare_value("o_commit_inst", e.inst, o_commit_inst);
        compare_value("o_commit_mem_en", e.mem_en, o_commit_mem_en);
        compare_value("o_commit_mem_addr", e.mem_addr, o_commit_mem_addr);
        compare_value("o_bypass_gpr_valid", e.gpr_wen, o_bypass_gpr_valid);
        compare_value("o_bypass_csr_valid", e.csr_wen, o_bypass_csr_valid);
        if (e.gpr_wen) begin
          compare_value("o_bypass_gpr_addr", e.rd, o_bypass_gpr_addr);
          compare_value("o_bypass_gpr_data", e.result, o_bypass_gpr_data);
          if (e.rd != 0) model_gpr[e.rd] = e.result;
        end
        if (e.csr_wen) begin
          compare_value("o_bypass_csr_addr", e.csr_addr, o_bypass_csr_addr);
          compare_value("o_bypass_csr_data", e.csr_data, o_bypass_csr_data);
          if (csr_index(e.csr_addr) >= 0) model_csr[csr_index(e.csr_addr)] = e.csr_data;
        end
        pend_rd  = e.rd;
        pend_csr = e.csr_addr;
      end
    end else begin
      // empty write-back slot publishes no bypass
      compare_value("o_bypass_gpr_valid", 0, o_bypass_gpr_valid);
      compare_value("o_bypass_csr_valid", 0, o_bypass_csr_valid);
    end
    accepted   = i_es_valid && o_es_allowin;
    hold       = i_es_valid && !o_es_allowin;
    load_in_ms = accepted && i_es_mem_ren;
    if (accepted) accept_instr();
  endtask

  initial begin
    while (cycles < CYC_LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d instructions accepted, %0d not retired",
             cycles, n_acc, exp_q.size());
    report_counts();
    $display("Something failed");
    $finish;
  end

  initial begin
    seed_dummy = $urandom(32'h40a90e16);
    {i_rst, i_es_valid, i_es_gpr_wen, i_es_mem_ren, i_es_mem_wen} = 5'b10000;
    {i_es_mem_unsigned, i_es_csr_wen} = 2'b00;
    {i_es_pc, i_es_alu_result, i_es_store_data, i_es_csr_wdata, i_es_inst} = '0;
    {i_es_rd, i_es_csr_addr, i_gpr_raddr1, i_gpr_raddr2, i_csr_raddr} = '0;
    i_es_mem_size = MEM_BYTE;
    {hold, load_in_ms, pend_valid, pend_rd, pend_csr} = '0;
    next_pc = 64'h8000_0000;
    for (int i = 0; i < DMEM_DEPTH; i++) model_mem[i] = '0;
    for (int i = 0; i < 32; i++) model_gpr[i] = '0;
    for (int i = 0; i < 4; i++) model_csr[i] = '0;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    while (n_acc < N_INSTR || exp_q.size() != 0) begin
      if (!hold) begin
        if (n_acc < N_INSTR && $urandom_range(0, 3) != 0) offer_instr();
        else i_es_valid = 1'b0;
      end
      i_gpr_raddr1 = pend_rd;
      i_csr_raddr  = pend_csr;
      @(negedge i_clk);
      cyc++;
      check_cycle();
      @(posedge i_clk);
      #1;
    end
    // sweep the register files once drained
    for (int r = 0; r < 32; r += 2) begin
      i_gpr_raddr1 = 5'(r);
      i_gpr_raddr2 = 5'(r + 1);
      @(negedge i_clk);
      compare_value("o_gpr_rdata1", model_gpr[r], o_gpr_rdata1);
      compare_value("o_gpr_rdata2", model_gpr[r+1], o_gpr_rdata2);
      @(posedge i_clk);
      #1;
    end
    for (int c = 0; c < 8; c++) begin
      i_csr_raddr = csr_probe[c];
      @(negedge i_clk);
      compare_value("o_csr_rdata", csr_expect(csr_probe[c]), o_csr_rdata);
      @(posedge i_clk);
      #1;
    end
    report_counts();
    if (n_value_err == 0 && n_other_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: all.f
src/core_pkg.sv
src/rf_write_if.sv
src/stage_slot.sv
src/data_mem.sv
src/mem_stage.sv
src/wb_stage.sv
src/gpr_file.sv
src/csr_file.sv
src/wb_core_top.sv
verification/tb_wb_core.sv
